/* vlog.f */
+incdir+testbench
source/predictorPkg.sv
source/resolveBus.sv
source/branchCounter.sv
source/branchTargetBuffer.sv
source/fetchSequencer.sv
source/branchPredictor.sv
testbench/tbBranchPredictor.sv

/* Makefile */
TOP := tbBranchPredictor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* testbench/btbModel.svh */
`ifndef BTB_MODEL_SVH
`define BTB_MODEL_SVH

// *************************************************************************
// reference model of the buffer contents and the fetch pc
// *************************************************************************

logic [1:0]                         modelState  [predictorPkg::BtbDepth];
logic [predictorPkg::DataWidth-1:0] modelTarget [predictorPkg::BtbDepth];
logic [predictorPkg::BtbDepth-1:0]  modelValid;
logic [predictorPkg::DataWidth-1:0] modelPc;
logic                               modelStarted;

// a weak state jumps to the strong end of the resolved direction.
// a strong state only creeps one step towards the other side.
function automatic logic [1:0] counterNext(input logic [1:0] state, input logic taken);
    logic [1:0] next;
    case ({taken, state})
        3'b100: next = 2'b01;
        3'b101: next = 2'b11;
        3'b110: next = 2'b11;
        3'b111: next = 2'b11;
        3'b011: next = 2'b10;
        3'b010: next = 2'b00;
        3'b001: next = 2'b00;
        default: next = 2'b00;
    endcase
    return next;
endfunction

// fall-through address of an instruction word.
function automatic logic [predictorPkg::DataWidth-1:0] sequentialPc(
    input logic [predictorPkg::DataWidth-1:0] pc
);
    return pc + 16'd1;
endfunction

`endif

/* testbench/tbBranchPredictor.sv */
`timescale 1ns/1ps

module tbBranchPredictor;

    localparam int ClkPeriod = 4;
    localparam int ResetCycles = 16;
    localparam int IdleCycles = 12;
    localparam int TrainCycles = 200;
    localparam int PlainCycles = 60;
    localparam int RedirectCycles = 120;
    localparam int StallCycles = 150;
    localparam int ResumeCycles = 30;
    localparam int TotalCycles = ResetCycles + IdleCycles + TrainCycles + PlainCycles
                               + RedirectCycles + StallCycles + ResumeCycles + 4;
    localparam int WatchdogCycles = TotalCycles + 100;

    logic                               clk;
    logic                               rstN;
    logic                               fetchEnable;
    logic                               resolveValid;
    logic [predictorPkg::DataWidth-1:0] resolvePc;
    logic [predictorPkg::DataWidth-1:0] resolveTarget;
    logic                               resolveTaken;
    logic                               resolveRegisterBranch;
    logic                               resolveMispredict;

    logic [predictorPkg::DataWidth-1:0] fetchPc;
    logic                               fetchValid;
    logic                               predTaken;
    logic                               predValid;
    logic [1:0]                         predState;
    logic [predictorPkg::DataWidth-1:0] predTarget;

    integer seed = 32'hc4a6153b;

    `include "btbModel.svh"

    branchPredictor u_dut (
        .clk                   (clk),
        .rstN                  (rstN),
        .fetchEnable           (fetchEnable),
        .resolveValid          (resolveValid),
        .resolvePc             (resolvePc),
        .resolveTarget         (resolveTarget),
        .resolveTaken          (resolveTaken),
        .resolveRegisterBranch (resolveRegisterBranch),
        .resolveMispredict     (resolveMispredict),
        .fetchPc               (fetchPc),
        .fetchValid            (fetchValid),
        .predTaken             (predTaken),
        .predValid             (predValid),
        .predState             (predState),
        .predTarget            (predTarget)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // *************************************************************************
    // expected outputs for the current cycle
    // *************************************************************************

    logic [predictorPkg::BtbIndexWidth-1:0] lookupIndex;
    logic [predictorPkg::BtbIndexWidth-1:0] trainIndex;
    logic [1:0]                             trainState;
    logic                                   expPredValid;
    logic [1:0]                             expPredState;
    logic [predictorPkg::DataWidth-1:0]     expPredTarget;
    logic                                   redirectNow;
    logic                                   predictNow;
    logic                                   expPredTaken;
    logic                                   expFetchValid;
    logic [predictorPkg::DataWidth-1:0]     expNextPc;

    assign lookupIndex = modelPc[predictorPkg::BtbIndexWidth-1:0];
    assign expPredValid = modelValid[lookupIndex];
    assign expPredState = modelState[lookupIndex];
    assign expPredTarget = modelTarget[lookupIndex];

    assign redirectNow = fetchEnable && resolveValid && resolveMispredict;
    assign predictNow = expPredValid && expPredState[1];
    assign expPredTaken = predictNow && !redirectNow;
    assign expFetchValid = modelStarted && fetchEnable;

    assign expNextPc = redirectNow ? (resolveTaken ? resolveTarget : sequentialPc(resolvePc))
                     : predictNow  ? expPredTarget
                     : sequentialPc(modelPc);

    // a fresh entry starts training from weak taken.
    assign trainIndex = resolvePc[predictorPkg::BtbIndexWidth-1:0];
    assign trainState = modelValid[trainIndex] ? modelState[trainIndex] : 2'b10;

    always @(posedge clk) begin
        if (!rstN) begin
            modelPc <= 16'h0000;
            modelValid <= '0;
            modelStarted <= 1'b0;
        end else begin
            modelStarted <= 1'b1;
            if (fetchEnable) begin
                if (resolveValid && resolveRegisterBranch) begin
                    modelState[trainIndex] <= counterNext(trainState, resolveTaken);
                    modelTarget[trainIndex] <= resolveTarget;
                    modelValid[trainIndex] <= 1'b1;
                end
                modelPc <= expNextPc;
            end
        end
    end

    // *************************************************************************
    // checks
    // *************************************************************************

    task automatic stopOnMismatch(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "DUT output mismatch");
    endtask

    assert property (@(posedge clk) disable iff (!rstN) fetchPc === modelPc)
    else begin
        stopOnMismatch($sformatf("fetchPc %h, expected %h",
                                 $sampled(fetchPc), $sampled(modelPc)));
    end

    assert property (@(posedge clk) disable iff (!rstN) predValid === expPredValid)
    else begin
        stopOnMismatch($sformatf("predValid %b, expected %b",
                                 $sampled(predValid), $sampled(expPredValid)));
    end

    assert property (@(posedge clk) disable iff (!rstN)
        expPredValid |-> (predState === expPredState && predTarget === expPredTarget))
    else begin
        stopOnMismatch($sformatf("entry state %b target %h, expected %b and %h",
                                 $sampled(predState), $sampled(predTarget),
                                 $sampled(expPredState), $sampled(expPredTarget)));
    end

    assert property (@(posedge clk) disable iff (!rstN) predTaken === expPredTaken)
    else begin
        stopOnMismatch($sformatf("predTaken %b, expected %b",
                                 $sampled(predTaken), $sampled(expPredTaken)));
    end

    assert property (@(posedge clk) disable iff (!rstN) fetchValid === expFetchValid)
    else begin
        stopOnMismatch($sformatf("fetchValid %b, expected %b",
                                 $sampled(fetchValid), $sampled(expFetchValid)));
    end

    // *************************************************************************
    // stimulus
    // *************************************************************************

    // pcs and targets share a small set of indexes, so fetch keeps landing
    // on entries that were trained.
    function automatic logic [predictorPkg::DataWidth-1:0] hotSetPc(input logic [15:0] raw);
        return {raw[15:6], 3'b000, raw[2:0]};
    endfunction

    // registerMode 0 clears registerBranch, 1 sets it and 2 picks at random.
    task automatic drivePhase(input int cycles, input bit reportsOn,
                              input logic [1:0] registerMode,
                              input bit mispredictOn, input bit stallOn);
        logic [31:0] word;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            word = $random(seed);
            fetchEnable = stallOn ? (word[1:0] != 2'b00) : 1'b1;
            resolveValid = reportsOn && (word[3:2] != 2'b00);
            resolveTaken = word[4];
            resolveMispredict = mispredictOn && word[5];
            case (registerMode)
                2'd0: resolveRegisterBranch = 1'b0;
                2'd1: resolveRegisterBranch = 1'b1;
                default: resolveRegisterBranch = word[6];
            endcase
            word = $random(seed);
            resolvePc = hotSetPc(word[15:0]);
            resolveTarget = hotSetPc(word[31:16]);
        end
    endtask

    initial begin
        rstN = 1'b0;
        fetchEnable = 1'b1;
        resolveValid = 1'b0;
        resolvePc = '0;
        resolveTarget = '0;
        resolveTaken = 1'b0;
        resolveRegisterBranch = 1'b0;
        resolveMispredict = 1'b0;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        drivePhase(IdleCycles, 1'b0, 2'd0, 1'b0, 1'b0);
        drivePhase(TrainCycles, 1'b1, 2'd1, 1'b0, 1'b0);
        drivePhase(PlainCycles, 1'b1, 2'd0, 1'b0, 1'b0);
        drivePhase(RedirectCycles, 1'b1, 2'd2, 1'b1, 1'b0);
        drivePhase(StallCycles, 1'b1, 2'd2, 1'b1, 1'b1);
        drivePhase(ResumeCycles, 1'b1, 2'd2, 1'b1, 1'b0);

        @(negedge clk);
        resolveValid = 1'b0;
        fetchEnable = 1'b1;
        repeat (2) @(posedge clk);

        // every mismatch stops the run, so reaching this point means no check failed.
        $display("TB PASSED");
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles.", WatchdogCycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* source/branchPredictor.sv */
`timescale 1ns/1ps

module branchPredictor (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               fetchEnable,

    input  logic                               resolveValid,
    input  logic [predictorPkg::DataWidth-1:0] resolvePc,
    input  logic [predictorPkg::DataWidth-1:0] resolveTarget,
    input  logic                               resolveTaken,
    input  logic                               resolveRegisterBranch,
    input  logic                               resolveMispredict,

    output logic [predictorPkg::DataWidth-1:0] fetchPc,
    output logic                               fetchValid,
    output logic                               predTaken,
    output logic                               predValid,
    output logic [1:0]                         predState,
    output logic [predictorPkg::DataWidth-1:0] predTarget
);

    resolveBus resolveIf ();

    assign resolveIf.valid = resolveValid;
    assign resolveIf.pc = resolvePc;
    assign resolveIf.target = resolveTarget;
    assign resolveIf.taken = resolveTaken;
    assign resolveIf.registerBranch = resolveRegisterBranch;
    assign resolveIf.mispredict = resolveMispredict;

    // the buffer looks up the address being fetched right now.
    branchTargetBuffer uBtb (
        .clk        (clk),
        .rstN       (rstN),
        .enable     (fetchEnable),
        .lookupPc   (fetchPc),
        .resolve    (resolveIf.trainer),
        .predValid  (predValid),
        .predState  (predState),
        .predTarget (predTarget)
    );

    fetchSequencer uSequencer (
        .clk        (clk),
        .rstN       (rstN),
        .enable     (fetchEnable),
        .resolve    (resolveIf.fetch),
        .predValid  (predValid),
        .predState  (predState),
        .predTarget (predTarget),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid),
        .predTaken  (predTaken)
    );

endmodule

/* source/fetchSequencer.sv */
`timescale 1ns/1ps

module fetchSequencer (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               enable,
    resolveBus.fetch                           resolve,
    input  logic                               predValid,
    input  logic [1:0]                         predState,
    input  logic [predictorPkg::DataWidth-1:0] predTarget,
    output logic [predictorPkg::DataWidth-1:0] fetchPc,
    output logic                               fetchValid,
    output logic                               predTaken
);

    logic                               redirect;
    logic [predictorPkg::DataWidth-1:0] redirectPc;
    logic                               predHit;
    logic [predictorPkg::DataWidth-1:0] nextPc;
    logic                               started;

    // *************************************************************************
    // next pc selection
    // *************************************************************************

    // a report only counts in an enabled cycle.
    // there is no back-pressure.
    assign redirect = enable && resolve.valid && resolve.mispredict;

    // the correct path is the target if taken, else the fall-through.
    assign redirectPc = resolve.taken ? resolve.target
                                      : resolve.pc + predictorPkg::PcStep;

    assign predHit = predValid && predState[1];

    // a redirect from execute wins over anything the buffer says.
    always_comb begin
        if (redirect) begin
            nextPc = redirectPc;
        end else if (predHit) begin
            nextPc = predTarget;
        end else begin
            nextPc = fetchPc + predictorPkg::PcStep;
        end
    end

    assign predTaken = predHit && !redirect;

    // *************************************************************************
    // fetch pc register
    // *************************************************************************

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchPc <= predictorPkg::ResetPc;
        end else if (enable) begin
            fetchPc <= nextPc;
        end
    end

    // the first cycle out of reset carries no fetch.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    assign fetchValid = started && enable;

    // *************************************************************************
    // checks
    // *************************************************************************

    // a stall must freeze the whole front end, fetchPc included.
    assert property (@(posedge clk) disable iff (!rstN)
        !enable |=> $stable(fetchPc))
    else begin
        $error("fetchPc moved while fetch was stalled");
    end

endmodule

/* source/branchTargetBuffer.sv */
`timescale 1ns/1ps

module branchTargetBuffer (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               enable,
    input  logic [predictorPkg::DataWidth-1:0] lookupPc,
    resolveBus.trainer                         resolve,
    output logic                               predValid,
    output logic [1:0]                         predState,
    output logic [predictorPkg::DataWidth-1:0] predTarget
);

    // each word is {state, target}.
    logic [predictorPkg::DataWidth+1:0] predArray [predictorPkg::BtbDepth];
    logic [predictorPkg::BtbDepth-1:0]  validVec;

    logic [predictorPkg::BtbIndexWidth-1:0] lookupIndex;
    logic [predictorPkg::DataWidth+1:0]     lookupEntry;

    logic [predictorPkg::BtbIndexWidth-1:0] updateIndex;
    logic [predictorPkg::DataWidth+1:0]     updateEntry;
    logic [1:0]                             counterIn;
    logic [1:0]                             counterOut;
    logic                                   updateEn;

    // *************************************************************************
    // lookup
    // *************************************************************************

    // no tags are kept, so two branches sharing low bits share an entry.
    assign lookupIndex = lookupPc[predictorPkg::BtbIndexWidth-1:0];
    assign lookupEntry = predArray[lookupIndex];

    assign predValid = validVec[lookupIndex];
    assign predState = lookupEntry[predictorPkg::DataWidth+:2];
    assign predTarget = lookupEntry[predictorPkg::DataWidth-1:0];

    // *************************************************************************
    // training
    // *************************************************************************

    assign updateEn = enable && resolve.valid && resolve.registerBranch;
    assign updateIndex = resolve.pc[predictorPkg::BtbIndexWidth-1:0];
    assign updateEntry = predArray[updateIndex];

    // an entry seen for the first time trains from the weak taken state.
    assign counterIn = validVec[updateIndex] ? updateEntry[predictorPkg::DataWidth+:2]
                                             : predictorPkg::ResetState;

    branchCounter uCounter (
        .stateIn  (counterIn),
        .taken    (resolve.taken),
        .stateOut (counterOut)
    );

    always_ff @(posedge clk) begin
        if (updateEn) begin
            predArray[updateIndex] <= {counterOut, resolve.target};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validVec <= '0;
        end else if (updateEn) begin
            validVec[updateIndex] <= 1'b1;
        end
    end

    // *************************************************************************
    // checks
    // *************************************************************************

    // a valid bit is only set together with a write, so a hit never reads
    // an uninitialized word.
    assert property (@(posedge clk) disable iff (!rstN)
        predValid |-> !$isunknown(predState))
    else begin
        $error("BTB hit with unknown state at index %0d", lookupIndex);
    end

endmodule

/* source/branchCounter.sv */
`timescale 1ns/1ps

// two-bit direction counter that leaves a weak state in one step.
// a weak state moves straight to the opposite strong state's side
// or to the strong state of the same side, never through the middle.
module branchCounter (
    input  logic [1:0] stateIn,
    input  logic       taken,
    output logic [1:0] stateOut
);

    always_comb begin
        stateOut = stateIn;
        if (taken) begin
            case (stateIn)
                predictorPkg::StrongNotTaken: begin
                    stateOut = predictorPkg::WeakNotTaken;
                end
                predictorPkg::WeakNotTaken: begin
                    stateOut = predictorPkg::StrongTaken;
                end
                default: begin
                    stateOut = predictorPkg::StrongTaken;
                end
            endcase
        end else begin
            case (stateIn)
                predictorPkg::StrongTaken: begin
                    stateOut = predictorPkg::WeakTaken;
                end
                predictorPkg::WeakTaken: begin
                    stateOut = predictorPkg::StrongNotTaken;
                end
                default: begin
                    stateOut = predictorPkg::StrongNotTaken;
                end
            endcase
        end
    end

endmodule

/* source/resolveBus.sv */
`timescale 1ns/1ps

// one resolved-branch report from the execute side of the pipeline.
interface resolveBus;

    logic                               valid;
    logic [predictorPkg::DataWidth-1:0] pc;
    logic [predictorPkg::DataWidth-1:0] target;
    logic                               taken;
    logic                               registerBranch;
    logic                               mispredict;

    // the buffer only trains on indirect branches.
    modport trainer (
        input valid,
        input pc,
        input target,
        input taken,
        input registerBranch
    );

    // fetch only reacts to wrong predictions.
    modport fetch (
        input valid,
        input pc,
        input target,
        input taken,
        input mispredict
    );

endinterface

/* source/predictorPkg.sv */
package predictorPkg;

    // *************************************************************************
    // address and buffer geometry
    // *************************************************************************

    // width of a fetch address and of a branch target.
    localparam int DataWidth = 16;

    // the buffer is direct mapped and indexed by the low address bits only.
    localparam int BtbDepth = 64;
    localparam int BtbIndexWidth = $clog2(BtbDepth);

    // first fetch address after reset.
    localparam logic [DataWidth-1:0] ResetPc = '0;

    // sequential fetch advances by one instruction word.
    localparam logic [DataWidth-1:0] PcStep = 1;

    // *************************************************************************
    // direction counter states
    // *************************************************************************

    // the upper bit of a state is the predicted direction.
    localparam logic [1:0] StrongNotTaken = 2'b00;
    localparam logic [1:0] WeakNotTaken = 2'b01;
    localparam logic [1:0] WeakTaken = 2'b10;
    localparam logic [1:0] StrongTaken = 2'b11;

    // an entry with no history starts out leaning towards taken.
    localparam logic [1:0] ResetState = WeakTaken;

endpackage
